// ==== verilog/pat_settings.svh ====
`ifndef PAT_SETTINGS_SVH
`define PAT_SETTINGS_SVH

// ==============================
// datapath widths
// ==============================

// data and register width
`define PAT_DATA_WIDTH 8

// instruction address width, 1k words
`define PAT_PC_WIDTH 10

// ==============================
// register file
// ==============================

`define PAT_NUM_REGS 8        // data registers r0..r7
`define PAT_REG_ADR_WIDTH 3   // log2 of the register count

// ==============================
// io and pipeline
// ==============================

// input bytes reachable by IN, selected one-hot
`define PAT_NUM_INPUTS 3

// instructions behind a taken branch that never commit
// (decode slot, arrival slot and the word still in flight)
`define PAT_SQUASH_SLOTS 3

`endif

// ==== verilog/pat_pkg.sv ====
`include "pat_settings.svh"

package pat_pkg;

	// ==============================
	// opcode spaces
	// ==============================

	// i8 space, 4'b1111 escapes into i3
	typedef enum logic [3:0]
	{
		I8_ORI       = 4'b0000,
		I8_ORR       = 4'b0001,
		I8_ANDI      = 4'b0010,
		I8_ANDR      = 4'b0011,
		I8_ADDI      = 4'b0100,
		I8_ADDR      = 4'b0101,
		I8_SUBI      = 4'b0110,
		I8_SUBR      = 4'b0111,
		I8_LDI       = 4'b1000,
		I8_BF        = 4'b1101,
		I8_I3_PREFIX = 4'b1111
	} pat_i8_op_e;

	// i3 space lives in imm8[7:4], 4'b1111 escapes into i0
	typedef enum logic [3:0]
	{
		I3_SHLZI     = 4'b0000,
		I3_SHLZR     = 4'b0001,
		I3_SHLOI     = 4'b0010,
		I3_SHLOR     = 4'b0011,
		I3_SHRZI     = 4'b0100,
		I3_SHRZR     = 4'b0101,
		I3_ASRI      = 4'b0110,
		I3_ASRR      = 4'b0111,
		I3_IN        = 4'b1010,
		I3_OUT       = 4'b1011,
		I3_I0_PREFIX = 4'b1111
	} pat_i3_op_e;

	// i0 space lives in imm8[3:0]
	typedef enum logic [3:0]
	{
		I0_NOT  = 4'b0000,
		I0_TEST = 4'b0010,
		I0_NOP  = 4'b1111
	} pat_i0_op_e;

	typedef enum logic [1:0] {COND_Z, COND_NZ, COND_N, COND_AL} pat_cond_e;

	typedef enum logic [3:0]
	{
		ALU_OR, ALU_AND, ALU_ADD, ALU_SUB, ALU_PASS,
		ALU_NOT, ALU_SHLZ, ALU_SHLO, ALU_SHRZ, ALU_ASR
	} pat_alu_op_e;

	// ==============================
	// structs between the stages
	// ==============================

	typedef struct packed
	{
		logic [`PAT_REG_ADR_WIDTH-1:0] rn; // destination and first source
		pat_cond_e cond;
		pat_i8_op_e op8;
		logic [7:0] imm8;                  // i3 op / spare bit / imm3 when prefixed
	} pat_instr_t;

	typedef struct packed
	{
		logic [`PAT_DATA_WIDTH-1:0] in0;
		logic [`PAT_DATA_WIDTH-1:0] in1;
		logic [`PAT_DATA_WIDTH-1:0] in2;
	} pat_in_bus_t;

	// decode -> execute control word
	typedef struct packed
	{
		pat_alu_op_e alu_op;
		logic [`PAT_REG_ADR_WIDTH-1:0] rd;
		logic [`PAT_DATA_WIDTH-1:0] a;     // R[rn]
		logic [`PAT_DATA_WIDTH-1:0] b;     // immediate, R[imm] or input byte
		logic write_reg;
		logic is_out;
		logic is_test;
		logic is_branch;
		pat_cond_e cond;
		logic [7:0] offset;                // signed branch distance
		logic [`PAT_PC_WIDTH-1:0] pc;      // address of this instruction
	} pat_exec_ctl_t;

	// i3 prefix, i0 prefix, i0 NOP
	localparam pat_instr_t instr_nop = '{rn: '0, cond: COND_AL, op8: I8_I3_PREFIX, imm8: 8'hff};

endpackage

// ==== verilog/pat_reg_file.sv ====
`include "pat_settings.svh"

module pat_reg_file
(
	input  logic clk,
	input  logic reset,
	input  logic [`PAT_REG_ADR_WIDTH-1:0] i_rd_adr_a,
	input  logic [`PAT_REG_ADR_WIDTH-1:0] i_rd_adr_b,
	output logic [`PAT_DATA_WIDTH-1:0] o_rd_data_a,
	output logic [`PAT_DATA_WIDTH-1:0] o_rd_data_b,
	input  logic i_wr_en,
	input  logic [`PAT_REG_ADR_WIDTH-1:0] i_wr_adr,
	input  logic [`PAT_DATA_WIDTH-1:0] i_wr_data
);

	logic [`PAT_DATA_WIDTH-1:0] regs [`PAT_NUM_REGS];

	// single write port, commit at the end of execute
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `PAT_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (i_wr_en)
			regs[i_wr_adr] <= i_wr_data;
	end

	// ==============================
	// write-through reads
	// ==============================

	// a write in the same cycle wins, so dependent neighbours need no stall
	assign o_rd_data_a = (i_wr_en && (i_wr_adr == i_rd_adr_a)) ? i_wr_data : regs[i_rd_adr_a];
	assign o_rd_data_b = (i_wr_en && (i_wr_adr == i_rd_adr_b)) ? i_wr_data : regs[i_rd_adr_b];

endmodule

// ==== verilog/pat_program_counter.sv ====
`include "pat_settings.svh"

module pat_program_counter
(
	input  logic clk,
	input  logic reset,
	input  logic i_jump,                        // taken branch, from execute
	input  logic [`PAT_PC_WIDTH-1:0] i_target,
	output logic [`PAT_PC_WIDTH-1:0] o_pc       // fetch address to instruction memory
);

	logic [`PAT_PC_WIDTH-1:0] pc_next;

	// ==============================
	// next address
	// ==============================

	// target arrives already formed, so one mux covers step and jump
	assign pc_next = i_jump ? i_target : o_pc + `PAT_PC_WIDTH'(1);

	// no stalls, the address moves every cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else
			o_pc <= pc_next;
	end

endmodule

// ==== verilog/pat_decoder.sv ====
`include "pat_settings.svh"

module pat_decoder
(
	input  logic clk,
	input  logic reset,
	input  pat_pkg::pat_instr_t i_instruction,  // one cycle behind i_pc
	input  logic [`PAT_PC_WIDTH-1:0] i_pc,
	input  pat_pkg::pat_in_bus_t i_inputs,
	input  logic i_flush,                       // taken branch in execute
	output logic [`PAT_REG_ADR_WIDTH-1:0] o_rd_adr_a,
	output logic [`PAT_REG_ADR_WIDTH-1:0] o_rd_adr_b,
	input  logic [`PAT_DATA_WIDTH-1:0] i_rd_data_a,
	input  logic [`PAT_DATA_WIDTH-1:0] i_rd_data_b,
	output pat_pkg::pat_exec_ctl_t o_exec
);
	import pat_pkg::*;

	logic [`PAT_PC_WIDTH-1:0] arr_pc;   // address of the word now on i_instruction
	logic [1:0] drop_cnt;               // arriving words still to be discarded
	pat_instr_t dec_instr;              // decode slot
	logic [`PAT_PC_WIDTH-1:0] dec_pc;
	pat_i3_op_e i3_op;
	pat_i0_op_e i0_op;
	logic [`PAT_DATA_WIDTH-1:0] imm3_ext;
	logic [`PAT_NUM_INPUTS-1:0] in_sel;
	logic [`PAT_DATA_WIDTH-1:0] in_byte;
	pat_exec_ctl_t ctl;

	// ==============================
	// arrival -> decode slot
	// ==============================
	always_ff @(posedge clk)
	begin
		arr_pc <= i_pc;    // memory answers a cycle late, so the pc does too
		dec_pc <= arr_pc;
		if (reset)
		begin
			dec_instr <= instr_nop;
			drop_cnt <= 2'd1;    // bus word seen in the first cycle is stale
		end
		else if (i_flush)
		begin
			dec_instr <= instr_nop;
			drop_cnt <= 2'(`PAT_SQUASH_SLOTS - 2);   // two slots already cleared here
		end
		else
		begin
			dec_instr <= (drop_cnt != 2'd0) ? instr_nop : i_instruction;
			if (drop_cnt != 2'd0)
				drop_cnt <= drop_cnt - 2'd1;
		end
	end

	// register reads happen in decode, the file bypasses same-cycle writes
	assign o_rd_adr_a = dec_instr.rn;
	assign o_rd_adr_b = dec_instr.imm8[`PAT_REG_ADR_WIDTH-1:0];

	assign i3_op = pat_i3_op_e'(dec_instr.imm8[7:4]);
	assign i0_op = pat_i0_op_e'(dec_instr.imm8[3:0]);
	assign imm3_ext = {{(`PAT_DATA_WIDTH-3){1'b0}}, dec_instr.imm8[2:0]};
	assign in_sel = dec_instr.imm8[`PAT_NUM_INPUTS-1:0];

	// one-hot input select, bad codes fall back to in0
	always_comb
	begin
		case (in_sel)
			3'b010: in_byte = i_inputs.in1;
			3'b100: in_byte = i_inputs.in2;
			default: in_byte = i_inputs.in0;
		endcase
	end

	// ==============================
	// decode of the three spaces
	// ==============================
	always_comb
	begin
		ctl = '0;
		ctl.alu_op = ALU_PASS;
		ctl.rd = dec_instr.rn;
		ctl.a = i_rd_data_a;
		ctl.b = dec_instr.op8[0] ? i_rd_data_b : dec_instr.imm8;   // odd code = register form
		ctl.cond = dec_instr.cond;
		ctl.offset = dec_instr.imm8;
		ctl.pc = dec_pc;
		if (dec_instr.op8 != I8_I3_PREFIX)
		begin
			ctl.write_reg = 1'b1;
			case (dec_instr.op8)
				I8_ORI, I8_ORR: ctl.alu_op = ALU_OR;
				I8_ANDI, I8_ANDR: ctl.alu_op = ALU_AND;
				I8_ADDI, I8_ADDR: ctl.alu_op = ALU_ADD;
				I8_SUBI, I8_SUBR: ctl.alu_op = ALU_SUB;
				I8_LDI: ctl.alu_op = ALU_PASS;   // b already holds imm8
				I8_BF:
				begin
					ctl.write_reg = 1'b0;
					ctl.is_branch = 1'b1;
				end
				default: ctl.write_reg = 1'b0;   // undefined, behaves as NOP
			endcase
		end
		else if (i3_op != I3_I0_PREFIX)
		begin
			ctl.b = i3_op[0] ? i_rd_data_b : imm3_ext;
			ctl.write_reg = 1'b1;
			case (i3_op)
				I3_SHLZI, I3_SHLZR: ctl.alu_op = ALU_SHLZ;
				I3_SHLOI, I3_SHLOR: ctl.alu_op = ALU_SHLO;
				I3_SHRZI, I3_SHRZR: ctl.alu_op = ALU_SHRZ;
				I3_ASRI, I3_ASRR: ctl.alu_op = ALU_ASR;
				I3_IN: ctl.b = in_byte;   // pass straight through
				I3_OUT:
				begin
					ctl.write_reg = 1'b0;
					ctl.is_out = 1'b1;
				end
				default: ctl.write_reg = 1'b0;
			endcase
		end
		else
		begin
			case (i0_op)
				I0_NOT:
				begin
					ctl.alu_op = ALU_NOT;
					ctl.write_reg = 1'b1;
				end
				I0_TEST: ctl.is_test = 1'b1;
				default: ;   // NOP and spare codes
			endcase
		end
	end

	// all-zero word has no side effects, it is the execute NOP
	always_ff @(posedge clk)
	begin
		if (reset || i_flush)
			o_exec <= '0;
		else
			o_exec <= ctl;
	end

endmodule

// ==== verilog/pat_execute.sv ====
`include "pat_settings.svh"

module pat_execute
(
	input  logic clk,
	input  logic reset,
	input  pat_pkg::pat_exec_ctl_t i_exec,
	output logic o_wr_en,
	output logic [`PAT_REG_ADR_WIDTH-1:0] o_wr_adr,
	output logic [`PAT_DATA_WIDTH-1:0] o_wr_data,
	output logic o_jump,
	output logic [`PAT_PC_WIDTH-1:0] o_target,
	output logic [`PAT_DATA_WIDTH-1:0] o_out,
	output logic o_out_strobe
);
	import pat_pkg::*;

	logic z_flag;
	logic n_flag;
	logic is_sub;
	logic [`PAT_DATA_WIDTH-1:0] b_eff;
	logic [`PAT_DATA_WIDTH-1:0] sum;
	logic [2:0] shamt;
	logic [`PAT_DATA_WIDTH-1:0] shlz;
	logic [`PAT_DATA_WIDTH-1:0] shlo;
	logic [`PAT_DATA_WIDTH-1:0] shrz;
	logic [`PAT_DATA_WIDTH-1:0] asr;
	logic [`PAT_DATA_WIDTH-1:0] result;
	logic cond_met;
	logic [`PAT_PC_WIDTH-1:0] offset_ext;

	// ==============================
	// alu
	// ==============================

	// one adder, subtract as a + ~b + 1
	assign is_sub = (i_exec.alu_op == ALU_SUB);
	assign b_eff = is_sub ? ~i_exec.b : i_exec.b;
	assign sum = i_exec.a + b_eff + `PAT_DATA_WIDTH'(is_sub);

	// shifter, only the low 3 bits of b count
	assign shamt = i_exec.b[2:0];
	assign shlz = i_exec.a << shamt;
	assign shlo = ~(~i_exec.a << shamt);   // zeros into the inverse = ones into a
	assign shrz = i_exec.a >> shamt;
	assign asr = $signed(i_exec.a) >>> shamt;

	always_comb
	begin
		case (i_exec.alu_op)
			ALU_ADD, ALU_SUB: result = sum;
			ALU_OR: result = i_exec.a | i_exec.b;
			ALU_AND: result = i_exec.a & i_exec.b;
			ALU_NOT: result = ~i_exec.a;
			ALU_SHLZ: result = shlz;
			ALU_SHLO: result = shlo;
			ALU_SHRZ: result = shrz;
			ALU_ASR: result = asr;
			default: result = i_exec.b;   // PASS for LDI and IN
		endcase
	end

	// commit goes straight to the register file write port
	assign o_wr_en = i_exec.write_reg;
	assign o_wr_adr = i_exec.rd;
	assign o_wr_data = result;

	// flags move on TEST only
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z_flag <= 1'b0;
			n_flag <= 1'b0;
		end
		else if (i_exec.is_test)
		begin
			z_flag <= (i_exec.a == '0);
			n_flag <= i_exec.a[`PAT_DATA_WIDTH-1];   // sign bit
		end
	end

	// ==============================
	// branch resolution
	// ==============================
	always_comb
	begin
		case (i_exec.cond)
			COND_Z: cond_met = z_flag;
			COND_NZ: cond_met = !z_flag;
			COND_N: cond_met = n_flag;
			default: cond_met = 1'b1;   // AL
		endcase
	end

	// high for the one cycle BF sits here, the slots behind it get flushed
	assign o_jump = i_exec.is_branch && cond_met;
	assign offset_ext = {{(`PAT_PC_WIDTH-8){i_exec.offset[7]}}, i_exec.offset};
	assign o_target = i_exec.pc + offset_ext;   // relative to the BF itself

	// output port, registered so the strobe lands a cycle after execute
	always_ff @(posedge clk)
	begin
		if (reset)
			o_out_strobe <= 1'b0;
		else
			o_out_strobe <= i_exec.is_out;
		if (i_exec.is_out)
			o_out <= i_exec.a;
	end

endmodule

// ==== verilog/pat_core.sv ====
`include "pat_settings.svh"

module pat_core
(
	input  logic clk,
	input  logic reset,
	input  pat_pkg::pat_instr_t i_instruction,   // word for the pc of the previous cycle
	input  pat_pkg::pat_in_bus_t i_inputs,
	output logic [`PAT_PC_WIDTH-1:0] o_pc,
	output logic o_jump,
	output logic [`PAT_DATA_WIDTH-1:0] o_out,
	output logic o_out_strobe
);
	import pat_pkg::*;

	// ==============================
	// stage wiring
	// ==============================
	logic [`PAT_PC_WIDTH-1:0] target;
	logic [`PAT_REG_ADR_WIDTH-1:0] rd_adr_a;
	logic [`PAT_REG_ADR_WIDTH-1:0] rd_adr_b;
	logic [`PAT_DATA_WIDTH-1:0] rd_data_a;
	logic [`PAT_DATA_WIDTH-1:0] rd_data_b;
	pat_exec_ctl_t exec_ctl;              // decode -> execute
	logic wr_en;
	logic [`PAT_REG_ADR_WIDTH-1:0] wr_adr;
	logic [`PAT_DATA_WIDTH-1:0] wr_data;

	pat_program_counter pc_i
	(
		.clk(clk),
		.reset(reset),
		.i_jump(o_jump),
		.i_target(target),
		.o_pc(o_pc)
	);

	// arrival + decode, flushed by the same jump that reloads the pc
	pat_decoder dec_i
	(
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.i_pc(o_pc),
		.i_inputs(i_inputs),
		.i_flush(o_jump),
		.o_rd_adr_a(rd_adr_a),
		.o_rd_adr_b(rd_adr_b),
		.i_rd_data_a(rd_data_a),
		.i_rd_data_b(rd_data_b),
		.o_exec(exec_ctl)
	);

	pat_reg_file rf_i
	(
		.clk(clk),
		.reset(reset),
		.i_rd_adr_a(rd_adr_a),
		.i_rd_adr_b(rd_adr_b),
		.o_rd_data_a(rd_data_a),
		.o_rd_data_b(rd_data_b),
		.i_wr_en(wr_en),
		.i_wr_adr(wr_adr),
		.i_wr_data(wr_data)
	);

	pat_execute exe_i
	(
		.clk(clk),
		.reset(reset),
		.i_exec(exec_ctl),
		.o_wr_en(wr_en),
		.o_wr_adr(wr_adr),
		.o_wr_data(wr_data),
		.o_jump(o_jump),
		.o_target(target),
		.o_out(o_out),
		.o_out_strobe(o_out_strobe)
	);

endmodule

// ==== tests/pat_chk.sv ====
`include "pat_settings.svh"

module pat_chk
(
	input logic clk,
	input logic reset,
	input logic [`PAT_PC_WIDTH-1:0] i_pc,
	input logic i_jump,
	input logic [`PAT_PC_WIDTH-1:0] i_target,   // jump target formed in execute
	input logic i_out_strobe
);
	timeunit 1ns;
	timeprecision 100ps;

	// ==============================
	// reset state
	// ==============================
	reset_state_a: assert property (@(posedge clk)
		$fell(reset) |-> (i_pc == '0 && !i_jump && !i_out_strobe))
		else $error("core not in its reset state in the first cycle after reset");

	// ==============================
	// program counter
	// ==============================

	// plain step when no jump was taken
	// the edge that releases reset still loads pc 0, so it starts no step
	pc_step_a: assert property (@(posedge clk) disable iff (reset)
		!reset && !i_jump |=> i_pc == $past(i_pc) + 1'b1)
		else $error("o_pc did not step by one");

	pc_target_a: assert property (@(posedge clk) disable iff (reset)
		i_jump |=> i_pc == $past(i_target))   // lands on the branch target
		else $error("o_pc did not load the jump target");

	// squashed slots can never jump again
	jump_gap_a: assert property (@(posedge clk) disable iff (reset)
		i_jump |=> !i_jump ##1 !i_jump ##1 !i_jump)
		else $error("o_jump raised again within three cycles");

endmodule

bind pat_core pat_chk chk_i
(
	.clk(clk),
	.reset(reset),
	.i_pc(o_pc),
	.i_jump(o_jump),
	.i_target(target),
	.i_out_strobe(o_out_strobe)
);

// ==== tests/pat_tb.sv ====
`include "pat_settings.svh"

module pat_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import pat_pkg::*;

	logic clk = 1'b0;
	logic reset;
	pat_instr_t i_instruction;
	pat_in_bus_t i_inputs;
	logic [`PAT_PC_WIDTH-1:0] o_pc;
	logic o_jump;
	logic [`PAT_DATA_WIDTH-1:0] o_out;
	logic o_out_strobe;

	pat_instr_t rom [1 << `PAT_PC_WIDTH];
	pat_in_bus_t in_bytes;
	logic [7:0] exp_q [$];     // expected OUT values, in order
	logic [7:0] exp_val;
	int wp;                    // next rom address to fill
	int exp_total;
	int strobe_cnt = 0;
	int mismatch_errs = 0;
	int other_errs = 0;
	int cyc;

	pat_core dut_i (.*);

	always #50 clk = ~clk;

	// synchronous instruction memory, answers a cycle late
	always @(posedge clk)
		i_instruction <= rom[o_pc];

	// ==============================
	// program building
	// ==============================
	function automatic pat_instr_t i8_word(pat_i8_op_e op, int rn, logic [7:0] imm);
		i8_word = '{rn: 3'(rn), cond: COND_AL, op8: op, imm8: imm};
	endfunction

	function automatic pat_instr_t i3_word(pat_i3_op_e op, int rn, logic [2:0] imm3);
		i3_word = '{rn: 3'(rn), cond: COND_AL, op8: I8_I3_PREFIX, imm8: {op, 1'b0, imm3}};
	endfunction

	function automatic pat_instr_t i0_word(pat_i0_op_e op, int rn);
		i0_word = '{rn: 3'(rn), cond: COND_AL, op8: I8_I3_PREFIX, imm8: {4'hf, op}};
	endfunction

	function automatic pat_instr_t branch_word(pat_cond_e c, int off);
		branch_word = '{rn: 3'd0, cond: c, op8: I8_BF, imm8: 8'(off)};
	endfunction

	task automatic emit(pat_instr_t w);
		rom[wp] = w;
		wp++;
	endtask

	// ==============================
	// sequential reference model
	// ==============================
	task automatic run_model;
		logic [7:0] r [8];
		logic [`PAT_PC_WIDTH-1:0] pc;
		logic [`PAT_PC_WIDTH-1:0] nxt;
		pat_instr_t w;
		pat_i3_op_e i3;
		logic [7:0] b;
		logic [7:0] v;
		logic [2:0] amt;
		logic z;
		logic n;
		logic taken;
		logic done;
		int steps;
		foreach (r[i])
			r[i] = '0;
		{pc, z, n, done, steps} = '0;
		while (!done && steps < 10000)
		begin
			w = rom[pc];
			nxt = pc + 1'b1;
			b = r[w.imm8[2:0]];              // register form source
			i3 = pat_i3_op_e'(w.imm8[7:4]);
			amt = i3[0] ? b[2:0] : w.imm8[2:0];
			v = r[w.rn];
			case (w.op8)
				I8_ORI: r[w.rn] = v | w.imm8;
				I8_ORR: r[w.rn] = v | b;
				I8_ANDI: r[w.rn] = v & w.imm8;
				I8_ANDR: r[w.rn] = v & b;
				I8_ADDI: r[w.rn] = v + w.imm8;
				I8_ADDR: r[w.rn] = v + b;
				I8_SUBI: r[w.rn] = v - w.imm8;
				I8_SUBR: r[w.rn] = v - b;
				I8_LDI: r[w.rn] = w.imm8;
				I8_BF:
				begin
					taken = (w.cond == COND_AL) || (w.cond == COND_Z && z) ||
						(w.cond == COND_NZ && !z) || (w.cond == COND_N && n);
					if (taken)
						nxt = pc + {{(`PAT_PC_WIDTH-8){w.imm8[7]}}, w.imm8};
					done = taken && (nxt == pc);   // final self-loop
				end
				I8_I3_PREFIX:
				begin
					case (i3)
						I3_SHLZI, I3_SHLZR: r[w.rn] = v << amt;
						I3_SHRZI, I3_SHRZR: r[w.rn] = v >> amt;
						I3_SHLOI, I3_SHLOR:
						begin
							for (int i = 0; i < amt; i++)
								v = {v[6:0], 1'b1};   // ones shift in
							r[w.rn] = v;
						end
						I3_ASRI, I3_ASRR:
						begin
							for (int i = 0; i < amt; i++)
								v = {v[7], v[7:1]};   // sign copied down
							r[w.rn] = v;
						end
						I3_IN: r[w.rn] = (w.imm8[2:0] == 3'b010) ? in_bytes.in1 :
							(w.imm8[2:0] == 3'b100) ? in_bytes.in2 : in_bytes.in0;
						I3_OUT: exp_q.push_back(v);
						I3_I0_PREFIX:
						begin
							if (w.imm8[3:0] == I0_NOT)
								r[w.rn] = ~v;
							else if (w.imm8[3:0] == I0_TEST)
								{z, n} = {v == 8'h00, v[7]};
						end
						default: ;
					endcase
				end
				default: ;   // undefined i8 codes do nothing
			endcase
			pc = nxt;
			steps++;
		end
		if (!done)
		begin
			$display("reference model never reached the final self-loop");
			other_errs++;
		end
	endtask

	// ==============================
	// output checks
	// ==============================
	always @(negedge clk)
	begin
		if (!reset && o_out_strobe)
		begin
			strobe_cnt++;
			if (exp_q.size() == 0)
			begin
				$display("unexpected output strobe at %0d ns with o_out %h", $time, o_out);
				other_errs++;
			end
			else
			begin
				exp_val = exp_q.pop_front();
				assert (o_out == exp_val)
				else
				begin
					$display("Mismatch at %0d ns: o_out expected %h received %h",
						$time, exp_val, o_out);
					mismatch_errs++;
				end
			end
		end
	end

	initial
	begin
		int back;
		int in_codes [4];
		void'($urandom(32'h7bcd));
		in_bytes = {8'($urandom), 8'($urandom), 8'($urandom)};
		foreach (rom[i])
			rom[i] = instr_nop;
		wp = 0;
		reset <= 1'b1;
		i_instruction <= instr_nop;
		i_inputs <= in_bytes;   // held for the whole program

		// logic and arithmetic, dependent neighbours
		emit(i8_word(I8_LDI, 1, 8'h35));
		emit(i3_word(I3_OUT, 1, 0));
		emit(i8_word(I8_ADDI, 1, 8'h1c));
		emit(i3_word(I3_OUT, 1, 0));
		emit(i8_word(I8_LDI, 2, 8'h0f));
		emit(i8_word(I8_ADDR, 1, 8'd2));
		emit(i3_word(I3_OUT, 1, 0));
		emit(i8_word(I8_SUBI, 1, 8'hf6));   // borrows, r1 ends at 6a
		emit(i3_word(I3_OUT, 1, 0));
		emit(i8_word(I8_SUBR, 2, 8'd1));
		emit(i3_word(I3_OUT, 2, 0));
		emit(i8_word(I8_ORI, 2, 8'h0c));    // overlapping bits, OR differs from ADD
		emit(i3_word(I3_OUT, 2, 0));
		emit(i8_word(I8_ORR, 1, 8'd2));
		emit(i3_word(I3_OUT, 1, 0));
		emit(i8_word(I8_ANDI, 1, 8'h5a));
		emit(i3_word(I3_OUT, 1, 0));
		emit(i8_word(I8_ANDR, 2, 8'd1));
		emit(i3_word(I3_OUT, 2, 0));
		emit(i0_word(I0_NOT, 2));
		emit(i3_word(I3_OUT, 2, 0));

		// every shift, both forms, all amounts
		for (int amt = 0; amt < 8; amt++)
			for (int k = 0; k < 8; k++)
			begin
				emit(i8_word(I8_LDI, 3, 8'(8'h96 + amt * 37 + k)));
				if (k % 2)
					emit(i8_word(I8_LDI, 4, 8'(amt | 8'hf8)));   // upper bits ignored
				emit(i3_word(pat_i3_op_e'(k), 3, (k % 2) ? 3'd4 : 3'(amt)));
				emit(i3_word(I3_OUT, 3, 0));
			end
		in_codes = '{1, 2, 4, 6};
		foreach (in_codes[i])
		begin
			emit(i3_word(I3_IN, 5, 3'(in_codes[i])));   // 6 is not one-hot
			emit(i3_word(I3_OUT, 5, 0));
		end

		// branches, squashed OUTs sit in the slots behind taken ones
		emit(i8_word(I8_LDI, 6, 8'h00));
		emit(i0_word(I0_TEST, 6));
		emit(branch_word(COND_Z, 3));
		emit(i3_word(I3_OUT, 1, 0));
		emit(i3_word(I3_OUT, 2, 0));
		emit(i3_word(I3_OUT, 6, 0));
		emit(branch_word(COND_NZ, 5));
		emit(i3_word(I3_OUT, 6, 0));
		emit(i8_word(I8_LDI, 6, 8'h80));
		emit(i0_word(I0_TEST, 6));
		emit(branch_word(COND_N, 4));
		emit(i3_word(I3_OUT, 1, 0));
		emit(i3_word(I3_OUT, 2, 0));
		emit(i3_word(I3_OUT, 3, 0));
		emit(i3_word(I3_OUT, 6, 0));
		emit(branch_word(COND_Z, 6));
		emit(i8_word(I8_LDI, 6, 8'h21));
		emit(i0_word(I0_TEST, 6));
		emit(branch_word(COND_N, 7));
		emit(i3_word(I3_OUT, 6, 0));
		emit(branch_word(COND_NZ, 2));
		emit(i3_word(I3_OUT, 1, 0));
		emit(i3_word(I3_OUT, 6, 0));
		emit(i8_word(I8_LDI, 7, 8'd3));   // backward loop, three turns
		back = wp;
		emit(i3_word(I3_OUT, 7, 0));
		emit(i8_word(I8_SUBI, 7, 8'd1));
		emit(i0_word(I0_TEST, 7));
		emit(branch_word(COND_NZ, back - wp));
		emit(branch_word(COND_AL, 2));
		emit(i3_word(I3_OUT, 2, 0));
		emit(branch_word(COND_AL, 0));   // final self-loop

		run_model();
		exp_total = exp_q.size();

		repeat (8) @(posedge clk);
		reset <= 1'b0;

		for (cyc = 0; cyc < 4000 && strobe_cnt < exp_total; cyc++)
			@(posedge clk);
		if (strobe_cnt < exp_total)
		begin
			$display("timed out waiting for %0d output strobes, saw %0d", exp_total, strobe_cnt);
			other_errs++;
		end
		else
		begin
			for (cyc = 0; cyc < 40; cyc++)   // room for stray strobes to show up
				@(posedge clk);
			if (strobe_cnt != exp_total)
			begin
				$display("strobe count %0d differs from the expected %0d",
					strobe_cnt, exp_total);
				other_errs++;
			end
		end

		$display("strobes %0d of %0d, mismatches %0d, other errors %0d",
			strobe_cnt, exp_total, mismatch_errs, other_errs);
		if (mismatch_errs + other_errs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/pat_pkg.sv
verilog/pat_reg_file.sv
verilog/pat_program_counter.sv
verilog/pat_decoder.sv
verilog/pat_execute.sv
verilog/pat_core.sv
tests/pat_chk.sv
tests/pat_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pat_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pat_tb -f compile.f -o pat_sim

# a failed assertion stops the binary, the search below still decides
out=$(./obj_dir/pat_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
	exit 0
fi
exit 1
